//--- src/tmr_cfg.svh
`ifndef TMR_CFG_SVH
`define TMR_CFG_SVH

// ==========================================================================
// receiver geometry
// ==========================================================================

// byte position of the copy number in a frame, from 0
`define ID_OFFSET 4

// payload bytes kept per copy
`define BANK_DEPTH 64

// must cover BANK_DEPTH - 1
`define BANK_ADDR_W 6

`endif

//--- src/rx_frame_pkg.sv
`include "tmr_cfg.svh"

package rx_frame_pkg;

	// ======================================================================
	// receive side types
	// ======================================================================

	typedef logic [7:0] byte_t;
	typedef logic [1:0] copy_id_t;                 // 1..3, 0 never stored
	typedef logic [`BANK_ADDR_W-1:0] bank_addr_t;
	typedef logic [`BANK_ADDR_W:0] pay_len_t;      // one extra bit for a full bank

	// one payload byte into one bank
	typedef struct packed {
		logic       we;
		copy_id_t   id;
		bank_addr_t addr;
		byte_t      data;
	} bank_write_t;

	// end of an accepted frame
	typedef struct packed {
		logic     done;
		copy_id_t id;
		pay_len_t len;
	} frame_end_t;

endpackage

//--- src/vote_pkg.sv
package vote_pkg;

	import rx_frame_pkg::*;

	// ======================================================================
	// voting side types
	// ======================================================================

	// bit 0 is copy 1
	typedef logic [2:0] copy_mask_t;

	// close or discard of a group; an empty mask means lost
	typedef struct packed {
		logic           start;
		copy_mask_t     mask;
		pay_len_t [2:0] len;    // len[0] belongs to copy 1
	} vote_req_t;

	// where the open group stands
	typedef enum logic [1:0] {
		GRP_EMPTY,              // no copy seen yet
		GRP_LAST1,              // last accepted copy was 1
		GRP_LAST2               // last accepted copy was 2
	} group_state_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_COMPARE,              // read all banks, clear agree flags
		S_DECIDE,               // pick winner or flag lost
		S_SEND                  // stream the winning bank
	} send_state_t;

endpackage

//--- src/frame_parser.sv
`timescale 1ns/1ps
`include "tmr_cfg.svh"

module frame_parser
	import rx_frame_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rx_en,
	input  byte_t       rx_data,
	input  logic        busy,
	output bank_write_t wr,
	output frame_end_t  fend
);

	localparam int OFF_W = $clog2(`ID_OFFSET + 2);
	localparam logic [OFF_W-1:0] ID_POS = OFF_W'(`ID_OFFSET);
	localparam pay_len_t DEPTH = pay_len_t'(`BANK_DEPTH);

	logic             rx_en_q;
	byte_t            rx_data_q;
	logic [OFF_W-1:0] off;          // saturates one past the ID byte
	logic             drop;
	logic             id_ok;
	copy_id_t         id_q;
	pay_len_t         cnt;          // payload bytes stored so far

	logic first_byte;
	logic drop_now;
	logic id_byte;
	logic id_valid;
	logic pay_byte;

	assign first_byte = rx_en_q && (off == '0);
	assign drop_now   = first_byte ? busy : drop;   // busy only counts at frame start
	assign id_byte    = rx_en_q && (off == ID_POS);
	assign id_valid   = (rx_data_q[3:0] >= 4'd1) && (rx_data_q[3:0] <= 4'd3);
	assign pay_byte   = rx_en_q && (off > ID_POS) && id_ok;

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_en_q <= 1'b0;
			off     <= '0;
			drop    <= 1'b0;
			id_ok   <= 1'b0;
			id_q    <= '0;
			cnt     <= '0;
		end else begin
			rx_en_q <= rx_en;
			if (rx_en_q) begin
				if (off <= ID_POS)
					off <= off + 1'b1;
				if (first_byte)
					drop <= busy;
				if (id_byte) begin
					id_ok <= !drop_now && id_valid;
					id_q  <= rx_data_q[1:0];
				end
				if (pay_byte && (cnt < DEPTH))
					cnt <= cnt + 1'b1;
			end else begin
				// gap between frames, rearm
				off   <= '0;
				drop  <= 1'b0;
				id_ok <= 1'b0;
				cnt   <= '0;
			end
		end
	end

	// bytes past a full bank are not written
	assign wr.we   = pay_byte && (cnt < DEPTH);
	assign wr.id   = id_q;
	assign wr.addr = cnt[`BANK_ADDR_W-1:0];
	assign wr.data = rx_data_q;

	// id_ok drops on this edge, so done lasts one cycle
	assign fend.done = !rx_en_q && id_ok;
	assign fend.id   = id_q;
	assign fend.len  = cnt;

endmodule

//--- src/copy_banks.sv
`timescale 1ns/1ps
`include "tmr_cfg.svh"

module copy_banks
	import rx_frame_pkg::*;
(
	input  logic        clk,
	input  bank_write_t wr,
	input  bank_addr_t  rd_addr,
	output byte_t [2:0] rd_data
);

	// ======================================================================
	// three payload memories, one per copy number
	// ======================================================================

	byte_t mem [3][`BANK_DEPTH];

	always_ff @(posedge clk) begin
		for (int b = 0; b < 3; b++) begin
			if (wr.we && (wr.id == copy_id_t'(b + 1)))
				mem[b][wr.addr] <= wr.data;
			rd_data[b] <= mem[b][rd_addr];  // all banks read together
		end
	end

endmodule

//--- src/copy_tracker.sv
`timescale 1ns/1ps

module copy_tracker
	import rx_frame_pkg::*, vote_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  frame_end_t fend,
	output vote_req_t  req
);

	group_state_t   state;
	copy_mask_t     mask;           // copies in the open group
	pay_len_t [2:0] len;
	pay_len_t [2:0] len_next;

	copy_mask_t   id_bit;
	group_state_t open_state;
	logic         out_of_order;

	assign id_bit     = copy_mask_t'(3'b001 << (fend.id - 2'd1));
	assign open_state = (fend.id == 2'd1) ? GRP_LAST1 : GRP_LAST2;

	// copy number not above the last one seen
	assign out_of_order = ((state == GRP_LAST1) && (fend.id <= 2'd1)) ||
	                      ((state == GRP_LAST2) && (fend.id <= 2'd2));

	always_comb begin
		len_next = len;
		len_next[fend.id - 2'd1] = fend.len;
	end

	always_ff @(posedge clk) begin
		if (fend.done)
			len <= len_next;
	end

	// ======================================================================
	// group FSM
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= GRP_EMPTY;
			mask  <= '0;
			req   <= '0;
		end else begin
			req.start <= 1'b0;
			if (fend.done) begin
				if (out_of_order) begin
					// old group is lost, this frame opens a new one
					req.start <= 1'b1;
					req.mask  <= '0;
					mask      <= id_bit;
					state     <= open_state;
				end else if (fend.id == 2'd3) begin
					req.start <= 1'b1;
					req.mask  <= mask | id_bit;
					req.len   <= len_next;
					mask      <= '0;
					state     <= GRP_EMPTY;
				end else begin
					mask  <= mask | id_bit;
					state <= open_state;
				end
			end
		end
	end

endmodule

//--- src/vote_sender.sv
`timescale 1ns/1ps

module vote_sender
	import rx_frame_pkg::*, vote_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  vote_req_t   req,
	input  byte_t [2:0] rd_data,
	output bank_addr_t  rd_addr,
	output logic        busy,
	output byte_t       out_data,
	output logic        out_en,
	output logic        lost
);

	send_state_t    state;
	copy_mask_t     mask_q;
	pay_len_t [2:0] len_q;
	logic [2:0]     agree;          // {2v3, 1v3, 1v2}
	logic [1:0]     sel;            // winning bank, 0 is copy 1
	pay_len_t       pass_len;       // addresses to read in this pass
	pay_len_t       cnt;
	bank_addr_t     rd_pos;         // address behind rd_data
	logic           rd_valid;

	pay_len_t   max_len;
	logic [1:0] win;
	logic       win_ok;
	logic [2:0] in_len;
	logic       pass_done;

	assign busy      = (state != S_IDLE);
	assign pass_done = (cnt == pass_len);

	// longest copy present in the request
	always_comb begin
		max_len = '0;
		for (int k = 0; k < 3; k++) begin
			if (req.mask[k] && (req.len[k] > max_len))
				max_len = req.len[k];
		end
	end

	assign in_len[0] = {1'b0, rd_pos} < len_q[0];
	assign in_len[1] = {1'b0, rd_pos} < len_q[1];
	assign in_len[2] = {1'b0, rd_pos} < len_q[2];

	// ======================================================================
	// winner order
	// ======================================================================

	always_comb begin
		win    = 2'd0;
		win_ok = 1'b1;
		case (mask_q)
			3'b111: begin
				if (agree[0] || agree[1])
					win = 2'd0;
				else if (agree[2])
					win = 2'd1;
				else
					win_ok = 1'b0;
			end
			3'b011: win_ok = agree[0];
			3'b101: win_ok = agree[1];
			3'b110: begin
				win    = 2'd1;
				win_ok = agree[2];
			end
			default: win_ok = 1'b0;  // empty, single copy
		endcase
	end

	always_ff @(posedge clk) begin
		out_data <= rd_data[sel];
	end

	// ======================================================================
	// sender FSM
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			mask_q   <= '0;
			len_q    <= '0;
			agree    <= '0;
			sel      <= '0;
			pass_len <= '0;
			cnt      <= '0;
			rd_addr  <= '0;
			rd_pos   <= '0;
			rd_valid <= 1'b0;
			out_en   <= 1'b0;
			lost     <= 1'b0;
		end else begin
			lost   <= 1'b0;
			out_en <= (state == S_SEND) && rd_valid;
			rd_pos <= rd_addr;
			case (state)
				S_IDLE: begin
					if (req.start) begin
						mask_q   <= req.mask;
						len_q    <= req.len;
						agree    <= {req.len[1] == req.len[2],
						             req.len[0] == req.len[2],
						             req.len[0] == req.len[1]};
						pass_len <= max_len;
						cnt      <= '0;
						rd_addr  <= '0;
						rd_valid <= 1'b0;
						state    <= S_COMPARE;
					end
				end
				S_COMPARE: begin
					if (rd_valid) begin
						if (in_len[0] && in_len[1] && (rd_data[0] != rd_data[1]))
							agree[0] <= 1'b0;
						if (in_len[0] && in_len[2] && (rd_data[0] != rd_data[2]))
							agree[1] <= 1'b0;
						if (in_len[1] && in_len[2] && (rd_data[1] != rd_data[2]))
							agree[2] <= 1'b0;
					end
					if (pass_done) begin
						rd_valid <= 1'b0;
						state    <= S_DECIDE;
					end else begin
						rd_valid <= 1'b1;
						cnt      <= cnt + 1'b1;
						rd_addr  <= rd_addr + 1'b1;
					end
				end
				S_DECIDE: begin
					if (!win_ok) begin
						lost  <= 1'b1;
						state <= S_IDLE;
					end else if (len_q[win] == '0) begin
						state <= S_IDLE;    // empty payload, nothing to send
					end else begin
						sel      <= win;
						pass_len <= len_q[win];
						cnt      <= '0;
						rd_addr  <= '0;
						state    <= S_SEND;
					end
				end
				S_SEND: begin
					// same read pipeline as the compare pass
					if (pass_done) begin
						rd_valid <= 1'b0;
						state    <= S_IDLE;
					end else begin
						rd_valid <= 1'b1;
						cnt      <= cnt + 1'b1;
						rd_addr  <= rd_addr + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- src/tmr_rx_top.sv
`timescale 1ns/1ps

module tmr_rx_top
	import rx_frame_pkg::*, vote_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  rx_en,
	input  byte_t rx_data,
	output byte_t out_data,
	output logic  out_en,
	output logic  lost,
	output logic  busy
);

	bank_write_t wr;
	frame_end_t  fend;
	vote_req_t   req;
	bank_addr_t  rd_addr;
	byte_t [2:0] rd_data;

	frame_parser u_parser (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx_en   (rx_en),
		.rx_data (rx_data),
		.busy    (busy),
		.wr      (wr),
		.fend    (fend)
	);

	copy_banks u_banks (
		.clk     (clk),
		.wr      (wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	copy_tracker u_tracker (
		.clk   (clk),
		.rst_n (rst_n),
		.fend  (fend),
		.req   (req)
	);

	vote_sender u_sender (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.rd_data  (rd_data),
		.rd_addr  (rd_addr),
		.busy     (busy),
		.out_data (out_data),
		.out_en   (out_en),
		.lost     (lost)
	);

endmodule

//--- verification/tmr_rx_tb.sv
`timescale 1ns/1ps
`include "tmr_cfg.svh"

module tmr_rx_tb
	import rx_frame_pkg::*;
();

	localparam int CASE_WORDS = 512;
	localparam int DRIVE_DLY  = 5;          // ns after the rising edge

	logic  clk;
	logic  rst_n;
	logic  rx_en;
	byte_t rx_data;
	byte_t out_data;
	logic  out_en;
	logic  lost;
	logic  busy;

	logic [7:0]  case_mem [CASE_WORDS];
	int          frame_pos [$];             // word index of each frame record
	logic [8:0]  expect_q [$];              // bit 8 set means a lost pulse
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 0;

	tmr_rx_top dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_en    (rx_en),
		.rx_data  (rx_data),
		.out_data (out_data),
		.out_en   (out_en),
		.lost     (lost),
		.busy     (busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ======================================================================
	// helpers
	// ======================================================================

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// records: 01 frame, 02 expected bytes, 03 expected lost, 00 end
	task automatic load_cases();
		int         idx;
		int         len;
		int         total;
		logic [7:0] kind;
		$readmemh("verification/tmr_rx_cases.txt", case_mem);
		idx   = 0;
		total = 0;
		kind  = case_mem[0];
		while (kind !== 8'h00) begin
			case (kind)
				8'h01: begin
					len = case_mem[idx + 2];
					frame_pos.push_back(idx);
					total += `ID_OFFSET + 1 + len;
					idx += 3 + len;
				end
				8'h02: begin
					len = case_mem[idx + 1];
					for (int b = 0; b < len; b++)
						expect_q.push_back({1'b0, case_mem[idx + 2 + b]});
					idx += 2 + len;
				end
				8'h03: begin
					expect_q.push_back(9'h100);
					idx += 1;
				end
				default: fail_run($sformatf("case file has a bad record type at word %0d", idx));
			endcase
			kind = case_mem[idx];
		end
		assert (frame_pos.size() > 0) else fail_run("case file holds no frames");
		cycle_limit = 4 * total + 200;
	endtask

	task automatic send_frame(input int pos);
		logic [7:0] id;
		int         len;
		int         gap;
		id    = case_mem[pos + 1];
		len   = case_mem[pos + 2];
		rx_en = 1'b1;
		for (int h = 0; h < `ID_OFFSET; h++) begin
			rx_data = 8'($urandom);         // filler header
			next_cycle();
		end
		rx_data = id;
		next_cycle();
		for (int b = 0; b < len; b++) begin
			rx_data = case_mem[pos + 3 + b];
			next_cycle();
		end
		rx_en   = 1'b0;
		rx_data = 8'h00;
		repeat (3) next_cycle();            // done, then start, then busy
		while (busy)
			next_cycle();
		gap = 1 + ($urandom % 4);
		repeat (gap) next_cycle();
	endtask

	// ======================================================================
	// output checking, sampled away from the clock edge
	// ======================================================================

	task automatic check_output();
		logic [8:0] exp;
		assert (!(out_en && lost))
			else fail_run($sformatf("out_en and lost both high at %0t", $time));
		assert (expect_q.size() > 0)
			else fail_run($sformatf("output arrived at %0t when no result was expected", $time));
		exp = expect_q.pop_front();
		if (lost) begin
			assert (exp[8])
				else fail_run($sformatf("lost pulse at %0t while byte %02h was expected",
				                        $time, exp[7:0]));
		end else begin
			assert (!exp[8])
				else fail_run($sformatf("output byte at %0t while a lost pulse was expected",
				                        $time));
			assert (out_data == exp[7:0])
				else fail_run($sformatf("MISMATCH at time %0t: out_data %02h, expected %02h",
				                        $time, out_data, exp[7:0]));
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && (out_en || lost))
			check_output();
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit))
			fail_run($sformatf("timeout after %0d cycles", cycle_cnt));
	end

	// ======================================================================
	// stimulus
	// ======================================================================

	initial begin
		rst_n   = 1'b0;
		rx_en   = 1'b0;
		rx_data = 8'h00;
		void'($urandom(32'hf716));
		load_cases();
		repeat (5) @(posedge clk);
		#DRIVE_DLY rst_n = 1'b1;
		next_cycle();
		assert (!out_en && !lost && !busy)
			else fail_run("out_en, lost or busy not low after reset");
		foreach (frame_pos[i])
			send_frame(frame_pos[i]);
		repeat (4) next_cycle();            // last registered byte
		if (expect_q.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			fail_run($sformatf("%0d expected results never arrived", expect_q.size()));
		end
	end

endmodule

//--- verification/tmr_rx_cases.txt
// 01 id len payload = frame, 02 len bytes = expected output, 03 = expected lost
// 00 ends the list, all values hex
// three identical copies
01 01 05 11 22 33 44 55
01 02 05 11 22 33 44 55
01 03 05 11 22 33 44 55
02 05 11 22 33 44 55
// one copy corrupted, in turn
01 01 04 9A 02 03 04
01 02 04 01 02 03 04
01 03 04 01 02 03 04
02 04 01 02 03 04
01 01 06 A0 A1 A2 A3 A4 A5
01 02 06 A0 A1 A2 FF A4 A5
01 03 06 A0 A1 A2 A3 A4 A5
02 06 A0 A1 A2 A3 A4 A5
01 01 03 C0 C1 C2
01 02 03 C0 C1 C2
01 03 03 C0 C1 C3
02 03 C0 C1 C2
01 01 04 D0 D1 D2 D3            // copy 1 short by one byte
01 02 05 D0 D1 D2 D3 D4
01 03 05 D0 D1 D2 D3 D4
02 05 D0 D1 D2 D3 D4
// all three differ
01 01 03 10 20 30
01 02 03 10 21 30
01 03 03 11 20 31
03
// two-copy groups, then copy 3 alone
01 01 02 5A 5B
01 03 02 5A 5B
02 02 5A 5B
01 01 03 60 61 62
01 03 03 60 61 63
03
01 02 04 70 71 72 73
01 03 04 70 71 72 73
02 04 70 71 72 73
01 02 02 80 81
01 03 02 80 82
03
01 03 02 90 91
03
// 1 2 1 2 3, with invalid copy numbers mixed in
01 01 02 E0 E1
01 02 02 E0 E1
01 01 03 F0 F1 F2               // discards the open group
03
01 00 03 0F 0F 0F
01 02 03 F0 F1 F2
01 07 02 EE EE
01 03 03 F0 F1 F2
02 03 F0 F1 F2
00

//--- flist.f
+incdir+src
src/rx_frame_pkg.sv
src/vote_pkg.sv
src/frame_parser.sv
src/copy_banks.sv
src/copy_tracker.sv
src/vote_sender.sv
src/tmr_rx_top.sv
verification/tmr_rx_tb.sv
